// File: include/fft_settings.svh
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// frame geometry
`define FFT_POINTS      16
`define FFT_STAGES      4

// sample width at the ports
`define FFT_SAMPLE_W    16

// internal fixed-point word, 8 fraction bits
`define FFT_ACC_W       32
`define FFT_FRAC_SHIFT  8

// twiddle coefficients, 1.0 == 0x10000
`define FFT_TW_W        18
`define FFT_TW_FRAC     16

`endif

// File: verilog/fft_pkg.sv
`include "fft_settings.svh"

package fft_pkg;

    ////////////////////
    // scalar words
    ////////////////////

    // real input or output sample
    typedef logic signed [`FFT_SAMPLE_W-1:0] sample_t;

    // working word inside the transform
    typedef logic signed [`FFT_ACC_W-1:0] acc_t;

    typedef logic signed [`FFT_TW_W-1:0] twiddle_t;

    ////////////////////
    // composite words
    ////////////////////

    typedef struct packed {
        acc_t re;
        acc_t im;
    } cplx_t;

    // slot 0 in the low bits
    typedef sample_t [`FFT_POINTS-1:0] frame_t;

    // 5 and 6 are unused encodings
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_STAGE1 = 3'd1,
        ST_STAGE2 = 3'd2,
        ST_STAGE3 = 3'd3,
        ST_STAGE4 = 3'd4,
        ST_DONE   = 3'd7
    } stage_t;

endpackage

// File: verilog/sample_collector.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module sample_collector (
    input  logic             clk,
    input  logic             rst,
    input  fft_pkg::sample_t fir_d,
    input  logic             fir_valid,
    output fft_pkg::frame_t  frame,
    output logic             frame_ready
);

    localparam int CNT_W = $clog2(`FFT_POINTS);
    localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(`FFT_POINTS - 1);

    logic [CNT_W-1:0] slot;

    // slot counter and frame strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot        <= '0;
            frame_ready <= 1'b0;
        end else if (fir_valid) begin
            frame_ready <= (slot == LAST_SLOT);
            slot        <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
        end else begin
            frame_ready <= 1'b0;
        end
    end

    // each accepted sample lands in its own slot
    always_ff @(posedge clk) begin
        if (fir_valid) begin
            frame[slot] <= fir_d;
        end
    end

    // a full frame takes 16 accepted samples, so the strobe can't repeat
    a_ready_single: assert property (
        @(posedge clk) disable iff (rst)
        frame_ready |=> !frame_ready
    );

endmodule

// File: verilog/fft_stage_ctrl.sv
`timescale 1ns/1ps

module fft_stage_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            frame_ready,
    output fft_pkg::stage_t stage,
    output logic            core_done
);

    fft_pkg::stage_t next_stage;

    ////////////////////
    // next state
    ////////////////////

    // one butterfly stage per clock once a frame is in
    always_comb begin
        case (stage)
            fft_pkg::ST_IDLE: begin
                next_stage = frame_ready ? fft_pkg::ST_STAGE1 : fft_pkg::ST_IDLE;
            end
            fft_pkg::ST_STAGE1: begin
                next_stage = fft_pkg::ST_STAGE2;
            end
            fft_pkg::ST_STAGE2: begin
                next_stage = fft_pkg::ST_STAGE3;
            end
            fft_pkg::ST_STAGE3: begin
                next_stage = fft_pkg::ST_STAGE4;
            end
            fft_pkg::ST_STAGE4: begin
                next_stage = fft_pkg::ST_DONE;
            end
            default: begin
                next_stage = fft_pkg::ST_IDLE;
            end
        endcase
    end

    ////////////////////
    // state register
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage <= fft_pkg::ST_IDLE;
        end else begin
            stage <= next_stage;
        end
    end

    // buffer holds the finished transform during this state
    assign core_done = (stage == fft_pkg::ST_DONE);

    // collector must leave at least one frame time between strobes
    a_ready_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        frame_ready |-> (stage == fft_pkg::ST_IDLE)
    );

endmodule

// File: verilog/butterfly.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module butterfly (
    input  fft_pkg::cplx_t    a,
    input  fft_pkg::cplx_t    b,
    input  fft_pkg::twiddle_t w_re,
    input  fft_pkg::twiddle_t w_im,
    output fft_pkg::cplx_t    x,
    output fft_pkg::cplx_t    y
);

    localparam int PROD_W  = `FFT_ACC_W + `FFT_TW_W;
    localparam int KEEP_HI = `FFT_ACC_W + `FFT_TW_FRAC - 1;
    localparam int KEEP_LO = `FFT_TW_FRAC;

    fft_pkg::acc_t            diff_re;
    fft_pkg::acc_t            diff_im;
    fft_pkg::acc_t            ndiff_im;
    logic signed [PROD_W-1:0] prod_rr;
    logic signed [PROD_W-1:0] prod_ii;
    logic signed [PROD_W-1:0] prod_ri;
    logic signed [PROD_W-1:0] prod_ir;

    assign diff_re  = a.re - b.re;
    assign diff_im  = a.im - b.im;
    // (b-a).im feeds the real part directly, avoids negating a product
    assign ndiff_im = b.im - a.im;

    assign prod_rr = diff_re * w_re;
    assign prod_ii = ndiff_im * w_im;
    assign prod_ri = diff_re * w_im;
    assign prod_ir = diff_im * w_re;

    // upper leg is an exact sum, lower leg is (a-b)*W
    always_comb begin
        x.re = a.re + b.re;
        x.im = a.im + b.im;
        y.re = prod_rr[KEEP_HI:KEEP_LO] + prod_ii[KEEP_HI:KEEP_LO];
        y.im = prod_ri[KEEP_HI:KEEP_LO] + prod_ir[KEEP_HI:KEEP_LO];
    end

endmodule

// File: verilog/fft_datapath.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_datapath (
    input  logic            clk,
    input  logic            rst,
    input  fft_pkg::frame_t frame,
    input  logic            frame_ready,
    input  fft_pkg::stage_t stage,
    output fft_pkg::frame_t bins_re,
    output fft_pkg::frame_t bins_im
);

    localparam int NUM_BF = `FFT_POINTS / 2;
    localparam int IDX_W  = $clog2(`FFT_POINTS);
    localparam int TWI_W  = $clog2(NUM_BF);
    localparam int SHF_W  = $clog2(`FFT_STAGES);
    localparam int OUT_LO = `FFT_FRAC_SHIFT;
    localparam int OUT_HI = `FFT_FRAC_SHIFT + `FFT_SAMPLE_W - 1;

    // W16^k, k = 0..7
    localparam fft_pkg::twiddle_t TW_RE [NUM_BF] = '{
        18'sh10000, 18'sh0EC83, 18'sh0B504, 18'sh061F7,
        18'sh00000, -18'sh061F7, -18'sh0B504, -18'sh0EC83
    };
    localparam fft_pkg::twiddle_t TW_IM [NUM_BF] = '{
        18'sh00000, -18'sh061F7, -18'sh0B504, -18'sh0EC83,
        -18'sh10000, -18'sh0EC83, -18'sh0B504, -18'sh061F7
    };

    fft_pkg::cplx_t   buffer [`FFT_POINTS];
    fft_pkg::cplx_t   bf_x   [NUM_BF];
    fft_pkg::cplx_t   bf_y   [NUM_BF];
    logic [IDX_W-1:0] idx_a  [NUM_BF];
    logic [IDX_W-1:0] idx_b  [NUM_BF];
    logic [TWI_W-1:0] tw_idx [NUM_BF];
    logic [SHF_W-1:0] shift;
    logic [IDX_W-1:0] span;
    logic [IDX_W-1:0] mask;
    logic             stage_active;

    function automatic logic [IDX_W-1:0] bit_rev(input logic [IDX_W-1:0] v);
        for (int n = 0; n < IDX_W; n++) begin
            bit_rev[n] = v[IDX_W-1-n];
        end
    endfunction

    ////////////////////
    // stage pairing
    ////////////////////

    always_comb begin
        case (stage)
            fft_pkg::ST_STAGE2: shift = SHF_W'(1);
            fft_pkg::ST_STAGE3: shift = SHF_W'(2);
            fft_pkg::ST_STAGE4: shift = SHF_W'(3);
            default:            shift = '0;
        endcase
    end

    // span 8,4,2,1 and the bits below it
    assign span = IDX_W'(NUM_BF) >> shift;
    assign mask = span - 1'b1;

    // butterfly j takes the j-th index with the span bit clear
    always_comb begin
        for (int j = 0; j < NUM_BF; j++) begin
            idx_a[j]  = ((IDX_W'(j) & ~mask) << 1) | (IDX_W'(j) & mask);
            idx_b[j]  = idx_a[j] | span;
            tw_idx[j] = TWI_W'((IDX_W'(j) & mask) << shift);
        end
    end

    assign stage_active = stage inside {fft_pkg::ST_STAGE1, fft_pkg::ST_STAGE2,
                                        fft_pkg::ST_STAGE3, fft_pkg::ST_STAGE4};

    ////////////////////
    // butterflies
    ////////////////////

    for (genvar g = 0; g < NUM_BF; g++) begin : g_bf
        butterfly i_bf (
            .a    (buffer[idx_a[g]]),
            .b    (buffer[idx_b[g]]),
            .w_re (TW_RE[tw_idx[g]]),
            .w_im (TW_IM[tw_idx[g]]),
            .x    (bf_x[g]),
            .y    (bf_y[g])
        );
    end

    // load on the strobe, else every pair written back in place
    always_ff @(posedge clk) begin
        if (frame_ready) begin
            for (int k = 0; k < `FFT_POINTS; k++) begin
                buffer[k].re <= fft_pkg::acc_t'($signed(frame[k])) <<< `FFT_FRAC_SHIFT;
                buffer[k].im <= '0;
            end
        end else if (stage_active) begin
            for (int j = 0; j < NUM_BF; j++) begin
                buffer[idx_a[j]] <= bf_x[j];
                buffer[idx_b[j]] <= bf_y[j];
            end
        end
    end

    ////////////////////
    // readout
    ////////////////////

    // DIF leaves bins in bit-reversed slots
    always_comb begin
        for (int k = 0; k < `FFT_POINTS; k++) begin
            bins_re[k] = buffer[bit_rev(IDX_W'(k))].re[OUT_HI:OUT_LO];
            bins_im[k] = buffer[bit_rev(IDX_W'(k))].im[OUT_HI:OUT_LO];
        end
    end

    // controller only produces the six defined states
    a_stage_legal: assert property (
        @(posedge clk) disable iff (rst)
        stage inside {fft_pkg::ST_IDLE, fft_pkg::ST_STAGE1, fft_pkg::ST_STAGE2,
                      fft_pkg::ST_STAGE3, fft_pkg::ST_STAGE4, fft_pkg::ST_DONE}
    );

endmodule

// File: verilog/fft_output_seq.sv
`timescale 1ns/1ps

module fft_output_seq (
    input  logic            clk,
    input  logic            rst,
    input  logic            core_done,
    input  fft_pkg::frame_t bins_re,
    input  fft_pkg::frame_t bins_im,
    output fft_pkg::frame_t fft_d,
    output logic            fft_valid
);

    // high while the imaginary word is due at the next edge
    logic phase;

    ////////////////////
    // valid window
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= 1'b0;
            fft_valid <= 1'b0;
        end else begin
            phase     <= core_done;
            fft_valid <= core_done | phase;
        end
    end

    ////////////////////
    // output word
    ////////////////////

    // real parts first, imaginary parts one cycle later
    always_ff @(posedge clk) begin
        if (core_done) begin
            fft_d <= bins_re;
        end else if (phase) begin
            fft_d <= bins_im;
        end
    end

endmodule

// File: verilog/stream_done.sv
`timescale 1ns/1ps

module stream_done (
    input  logic clk,
    input  logic rst,
    input  logic fir_valid,
    input  logic fft_valid,
    output logic done
);

    logic fir_valid_q;
    logic fft_valid_q;
    logic in_end;
    logic out_end;
    // input has stopped, last result not out yet
    logic wait_drain;

    // falling edges of both strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_valid_q <= 1'b0;
            fft_valid_q <= 1'b0;
        end else begin
            fir_valid_q <= fir_valid;
            fft_valid_q <= fft_valid;
        end
    end

    assign in_end  = fir_valid_q & ~fir_valid;
    assign out_end = fft_valid_q & ~fft_valid;

    // clearing on done wins over a new input fall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_drain <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= wait_drain & out_end;
            if (wait_drain && out_end) begin
                wait_drain <= 1'b0;
            end else if (in_end) begin
                wait_drain <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/fft16.sv
`timescale 1ns/1ps

module fft16 (
    input  logic             clk,
    input  logic             rst,
    input  fft_pkg::sample_t fir_d,
    input  logic             fir_valid,
    output fft_pkg::frame_t  fft_d,
    output logic             fft_valid,
    output logic             done
);

    fft_pkg::frame_t frame;
    logic            frame_ready;
    fft_pkg::stage_t stage;
    logic            core_done;
    fft_pkg::frame_t bins_re;
    fft_pkg::frame_t bins_im;

    ////////////////////
    // input side
    ////////////////////

    sample_collector i_sample_collector (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    ////////////////////
    // transform
    ////////////////////

    fft_stage_ctrl i_fft_stage_ctrl (
        .clk         (clk),
        .rst         (rst),
        .frame_ready (frame_ready),
        .stage       (stage),
        .core_done   (core_done)
    );

    fft_datapath i_fft_datapath (
        .clk         (clk),
        .rst         (rst),
        .frame       (frame),
        .frame_ready (frame_ready),
        .stage       (stage),
        .bins_re     (bins_re),
        .bins_im     (bins_im)
    );

    ////////////////////
    // output side
    ////////////////////

    fft_output_seq i_fft_output_seq (
        .clk       (clk),
        .rst       (rst),
        .core_done (core_done),
        .bins_re   (bins_re),
        .bins_im   (bins_im),
        .fft_d     (fft_d),
        .fft_valid (fft_valid)
    );

    stream_done i_stream_done (
        .clk       (clk),
        .rst       (rst),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .done      (done)
    );

endmodule

// File: bench/fft_checker.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_checker (
    input  logic             clk,
    input  logic             rst,
    input  fft_pkg::sample_t fir_d,
    input  logic             fir_valid,
    input  fft_pkg::frame_t  fft_d,
    input  logic             fft_valid,
    input  logic             done,
    output int               error_count,
    output int               frames_checked,
    output int               done_count
);

    localparam int  N        = `FFT_POINTS;
    localparam int  IDX_W    = $clog2(N);
    // output rises 6 edges after the 16th sample, seen at the 7th
    localparam int  OUT_EDGE = 7;
    localparam real TWO_PI   = 6.283185307179586;
    localparam real TW_ONE   = real'(1 << `FFT_TW_FRAC);

    longint           tw_re [N/2];
    longint           tw_im [N/2];
    fft_pkg::sample_t captured [N];
    int               n_captured;
    longint           cycle;
    fft_pkg::frame_t  exp_re_q [$];
    fft_pkg::frame_t  exp_im_q [$];
    longint           due_q [$];
    fft_pkg::frame_t  new_re;
    fft_pkg::frame_t  new_im;
    logic             fir_valid_d;
    logic             fft_valid_d;
    // input has stopped since the last done
    logic             input_fell;
    logic             exp_done;

    // W16^k, magnitudes truncated toward zero
    initial begin
        for (int k = 0; k < N / 2; k++) begin
            tw_re[k] = $rtoi(TW_ONE * $cos(TWO_PI * k / N));
            tw_im[k] = -$rtoi(TW_ONE * $sin(TWO_PI * k / N));
        end
    end

    function automatic longint wrap_word(input longint v);
        return longint'(int'(v));
    endfunction

    // keep bits 47..16 of a twiddle product
    function automatic longint scale_product(input longint p);
        return longint'(int'(p >>> `FFT_TW_FRAC));
    endfunction

    function automatic int reverse_index(input int k);
        int r;
        r = 0;
        for (int b = 0; b < IDX_W; b++) begin
            r = (r << 1) | ((k >> b) & 1);
        end
        return r;
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // in-place DIF, pairs within a stage are disjoint
    task automatic run_model(output fft_pkg::frame_t re_w, output fft_pkg::frame_t im_w);
        longint br [N];
        longint bi [N];
        longint dr;
        longint di;
        int     span;
        int     j;
        int     t;
        for (int i = 0; i < N; i++) begin
            br[i] = longint'(captured[i]) <<< `FFT_FRAC_SHIFT;
            bi[i] = 0;
        end
        for (int st = 0; st < `FFT_STAGES; st++) begin
            span = (N / 2) >> st;
            for (int i = 0; i < N; i++) begin
                if ((i & span) == 0) begin
                    j  = i + span;
                    t  = (i % span) << st;
                    dr = wrap_word(br[i] - br[j]);
                    di = wrap_word(bi[i] - bi[j]);
                    br[i] = wrap_word(br[i] + br[j]);
                    bi[i] = wrap_word(bi[i] + bi[j]);
                    br[j] = wrap_word(scale_product(dr * tw_re[t])
                                      + scale_product(-di * tw_im[t]));
                    bi[j] = wrap_word(scale_product(dr * tw_im[t])
                                      + scale_product(di * tw_re[t]));
                end
            end
        end
        for (int k = 0; k < N; k++) begin
            re_w[k] = fft_pkg::sample_t'(br[reverse_index(k)] >>> `FFT_FRAC_SHIFT);
            im_w[k] = fft_pkg::sample_t'(bi[reverse_index(k)] >>> `FFT_FRAC_SHIFT);
        end
    endtask

    task automatic check_valid(input logic expected);
        if (fft_valid !== expected) begin
            $display("ERROR fft_valid at cycle %0d: expected %h got %h",
                     cycle, expected, fft_valid);
            error_count++;
        end
    endtask

    task automatic compare_word(input fft_pkg::frame_t expected, input string part);
        for (int k = 0; k < N; k++) begin
            if (fft_d[k] !== expected[k]) begin
                $display("ERROR fft_d[%0d] %s: expected %h got %h",
                         k, part, expected[k], fft_d[k]);
                error_count++;
            end
        end
    endtask

    ////////////////////
    // monitor
    ////////////////////

    always @(posedge clk) begin
        if (rst) begin
            error_count    = 0;
            frames_checked = 0;
            done_count     = 0;
            n_captured     = 0;
            cycle          = 0;
            fir_valid_d    = 1'b0;
            fft_valid_d    = 1'b0;
            input_fell     = 1'b0;
            exp_done       = 1'b0;
            exp_re_q.delete();
            exp_im_q.delete();
            due_q.delete();
        end else begin
            cycle++;
            // real word first, imaginary word right after
            if (due_q.size() > 0 && cycle == due_q[0]) begin
                check_valid(1'b1);
                compare_word(exp_re_q[0], "real");
            end else if (due_q.size() > 0 && cycle == due_q[0] + 1) begin
                check_valid(1'b1);
                compare_word(exp_im_q[0], "imag");
                exp_re_q.delete(0);
                exp_im_q.delete(0);
                due_q.delete(0);
                frames_checked++;
            end else begin
                check_valid(1'b0);
            end
            if (done !== exp_done) begin
                $display("ERROR done at cycle %0d: expected %h got %h", cycle, exp_done, done);
                error_count++;
            end
            if (done === 1'b1) begin
                done_count++;
            end
            // done one cycle after the burst ends, pending input fall consumed
            exp_done = input_fell && fft_valid_d && !fft_valid;
            if (exp_done) begin
                input_fell = 1'b0;
            end else if (fir_valid_d && !fir_valid) begin
                input_fell = 1'b1;
            end
            fir_valid_d = fir_valid;
            fft_valid_d = fft_valid;
            if (fir_valid) begin
                captured[n_captured] = fir_d;
                n_captured++;
                if (n_captured == N) begin
                    run_model(new_re, new_im);
                    exp_re_q.push_back(new_re);
                    exp_im_q.push_back(new_im);
                    due_q.push_back(cycle + OUT_EDGE);
                    n_captured = 0;
                end
            end
        end
    end

endmodule

// File: bench/tb_fft16.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module tb_fft16;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int WAIT_LIMIT   = 100;
    localparam int NUM_FRAMES   = 12;

    typedef enum logic [1:0] {
        PAT_CONST,
        PAT_IMPULSE,
        PAT_ALT,
        PAT_RANDOM
    } pattern_t;

    // last closes a burst, fir_valid then stays low until done
    typedef struct packed {
        pattern_t           kind;
        logic signed [15:0] amp;
        logic [1:0]         max_gap;
        logic               last;
    } frame_entry_t;

    // gapped burst first, then a burst with fir_valid held high
    localparam frame_entry_t STIM [NUM_FRAMES] = '{
        '{PAT_CONST,   16'sd100,   2'd3, 1'b0},
        '{PAT_CONST,   -16'sd1500, 2'd3, 1'b0},
        '{PAT_IMPULSE, 16'sd2047,  2'd3, 1'b0},
        '{PAT_IMPULSE, -16'sd777,  2'd3, 1'b0},
        '{PAT_ALT,     16'sd1024,  2'd3, 1'b0},
        '{PAT_ALT,     16'sd2047,  2'd3, 1'b0},
        '{PAT_RANDOM,  16'sd2047,  2'd3, 1'b0},
        '{PAT_RANDOM,  16'sd2047,  2'd3, 1'b1},
        '{PAT_RANDOM,  16'sd2047,  2'd0, 1'b0},
        '{PAT_CONST,   16'sd5,     2'd0, 1'b0},
        '{PAT_ALT,     -16'sd300,  2'd0, 1'b0},
        '{PAT_RANDOM,  16'sd2047,  2'd0, 1'b1}
    };

    logic             clk = 1'b0;
    logic             rst;
    fft_pkg::sample_t fir_d;
    logic             fir_valid;
    fft_pkg::frame_t  fft_d;
    logic             fft_valid;
    logic             done;
    int               checker_errors;
    int               frames_checked;
    int               done_count;
    int               bench_errors;
    int               frames_sent;
    int               burst_start_done;
    logic             burst_gapped;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fft16 i_fft16 (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_d     (fft_d),
        .fft_valid (fft_valid),
        .done      (done)
    );

    fft_checker i_checker (
        .clk            (clk),
        .rst            (rst),
        .fir_d          (fir_d),
        .fir_valid      (fir_valid),
        .fft_d          (fft_d),
        .fft_valid      (fft_valid),
        .done           (done),
        .error_count    (checker_errors),
        .frames_checked (frames_checked),
        .done_count     (done_count)
    );

    function automatic fft_pkg::sample_t pattern_value(input frame_entry_t e, input int slot);
        int span;
        case (e.kind)
            PAT_CONST:   return e.amp;
            PAT_IMPULSE: return (slot == 0) ? e.amp : '0;
            PAT_ALT:     return slot[0] ? -e.amp : e.amp;
            default: begin
                span = 2 * e.amp + 1;
                return fft_pkg::sample_t'(int'($urandom % span) - e.amp);
            end
        endcase
    endfunction

    // 16 samples, each followed by 0 to max_gap idle cycles
    task automatic send_frame(input frame_entry_t e);
        int gap;
        for (int slot = 0; slot < `FFT_POINTS; slot++) begin
            @(negedge clk);
            fir_d     = pattern_value(e, slot);
            fir_valid = 1'b1;
            gap = (e.max_gap == 0) ? 0 : int'($urandom % (int'(e.max_gap) + 1));
            repeat (gap) begin
                @(negedge clk);
                fir_valid = 1'b0;
            end
        end
        frames_sent++;
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (frames_checked < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (frames_checked < target) begin
            $display("timed out waiting for the output of frame %0d", target);
            bench_errors++;
        end
    endtask

    // stop the input, then exactly one done after the last output
    task automatic end_burst();
        int n;
        int base;
        @(negedge clk);
        fir_valid = 1'b0;
        wait_frames(frames_sent);
        if (!burst_gapped && done_count != burst_start_done) begin
            $display("done pulsed while frames of a gapless burst were arriving");
            bench_errors++;
        end
        base = done_count;
        n = 0;
        while (done_count == base && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_count == base) begin
            $display("timed out waiting for done after the last output");
            bench_errors++;
        end
        repeat (20) @(negedge clk);
        if (done_count > base + 1) begin
            $display("done pulsed more than once at the end of a burst");
            bench_errors++;
        end
        burst_start_done = done_count;
        burst_gapped     = 1'b0;
    endtask

    initial begin
        int seed;
        seed             = $urandom(50520);
        rst              = 1'b1;
        fir_d            = '0;
        fir_valid        = 1'b0;
        bench_errors     = 0;
        frames_sent      = 0;
        burst_start_done = 0;
        burst_gapped     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (STIM[i].max_gap != 0) begin
                burst_gapped = 1'b1;
            end
            send_frame(STIM[i]);
            if (STIM[i].last) begin
                end_burst();
            end
        end
        repeat (4) @(negedge clk);
        $display("frames checked %0d of %0d, checker errors %0d, bench errors %0d",
                 frames_checked, frames_sent, checker_errors, bench_errors);
        if (checker_errors == 0 && bench_errors == 0 && frames_checked == frames_sent) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+include
verilog/fft_pkg.sv
verilog/sample_collector.sv
verilog/fft_stage_ctrl.sv
verilog/butterfly.sv
verilog/fft_datapath.sv
verilog/fft_output_seq.sv
verilog/stream_done.sv
verilog/fft16.sv
bench/fft_checker.sv
bench/tb_fft16.sv

// File: Bender.yml
package:
  name: fft16

export_include_dirs:
  - include

sources:
  - verilog/fft_pkg.sv
  - verilog/sample_collector.sv
  - verilog/fft_stage_ctrl.sv
  - verilog/butterfly.sv
  - verilog/fft_datapath.sv
  - verilog/fft_output_seq.sv
  - verilog/stream_done.sv
  - verilog/fft16.sv
  - target: test
    files:
      - bench/fft_checker.sv
      - bench/tb_fft16.sv
